// ==== verilog/sc_map_pkg.sv ====
// widths and types shared by the subcarrier mapper blocks
// LANES must be 2 or more; lane 0 sits in the low bits of every word
`default_nettype none

package sc_map_pkg;

  parameter int SAMPLE_W = 8;                       // bits per real or imag sample
  parameter int LANES    = 4;                       // complex samples per input word

  // one real or imaginary sample
  typedef logic [SAMPLE_W-1:0] sample_t;

  // real or imag parts of a whole input word
  typedef logic [LANES*SAMPLE_W-1:0] lane_word_t;

  // stored word, imag lanes on top of real lanes
  typedef logic [2*LANES*SAMPLE_W-1:0] ram_word_t;

  typedef logic [5:0]  exp_t;                       // block exponent
  typedef logic [3:0]  symbol_t;                    // symbol in slot
  typedef logic [7:0]  slot_t;                      // slot in frame
  typedef logic [9:0]  frame_t;                     // radio frame number
  typedef logic [31:0] count_t;                     // event counter, wraps

  // read side sequencer
  typedef enum logic [1:0] {
    IDLE,                                           // nothing issued
    RUN,                                            // issuing frame indices
    DRAIN                                           // last sample leaving
  } rd_state_t;

endpackage

`default_nettype wire

// ==== verilog/sc_write_ctrl.sv ====
// input packets must be exactly SC_NUM/LANES words, sop on the first word
// a packet arriving with all blocks full is dropped whole and counted
`timescale 1ns/1ps
`default_nettype none

module sc_write_ctrl #(
  parameter  int SC_NUM    = 48,
  parameter  int BLOCK_QTY = 4,
  localparam int WORDS     = SC_NUM / sc_map_pkg::LANES,
  localparam int ADDR_W    = $clog2(BLOCK_QTY * WORDS),
  localparam int BLOC_W    = (BLOCK_QTY > 1) ? $clog2(BLOCK_QTY) : 1,
  localparam int USED_W    = $clog2(BLOCK_QTY + 1)
) (
  input  logic                   clk_rd,
  input  logic                   rst_n,
  input  logic                   din_valid,
  input  logic                   din_sop,
  input  logic                   din_eop,
  input  sc_map_pkg::lane_word_t din_real,
  input  sc_map_pkg::lane_word_t din_imag,
  input  sc_map_pkg::exp_t       din_exp,
  input  sc_map_pkg::symbol_t    din_symbol,
  input  sc_map_pkg::slot_t      din_slot,
  input  sc_map_pkg::frame_t     din_frame,
  input  logic                   bloc_release,        // one block freed by reader
  input  logic [BLOC_W-1:0]      rd_bloc,             // block now on the output
  output logic                   wr_en,
  output logic [ADDR_W-1:0]      wr_addr,
  output sc_map_pkg::ram_word_t  wr_data,
  output logic [USED_W-1:0]      bloc_used,           // committed blocks
  output sc_map_pkg::count_t     overflow_cnt,
  output sc_map_pkg::exp_t       rd_exp,
  output sc_map_pkg::symbol_t    rd_symbol,
  output sc_map_pkg::slot_t      rd_slot,
  output sc_map_pkg::frame_t     rd_frame
);

  localparam int OFFS_W = $clog2(WORDS + 1);          // room for WORDS itself
  localparam logic [BLOC_W-1:0] BLOC_LAST = BLOC_W'(BLOCK_QTY - 1);

  logic [BLOC_W-1:0]   wr_bloc;                       // block being filled
  logic [OFFS_W-1:0]   offs;                          // next word in packet
  logic [OFFS_W-1:0]   word_idx;
  logic                keep_r;                        // current packet is stored
  logic                commit_r;                      // block commit, eop + 1
  logic                sop_keep;
  logic                keep_now;
  logic [USED_W:0]     eff_used;

  sc_map_pkg::exp_t    exp_mem    [0:BLOCK_QTY-1];
  sc_map_pkg::symbol_t symbol_mem [0:BLOCK_QTY-1];
  sc_map_pkg::slot_t   slot_mem   [0:BLOCK_QTY-1];
  sc_map_pkg::frame_t  frame_mem  [0:BLOCK_QTY-1];

  // occupancy seen by a new sop, pending commit in, same-cycle release out
  assign eff_used = (USED_W+1)'(bloc_used) + (USED_W+1)'(commit_r)
                  - (USED_W+1)'(bloc_release);
  assign sop_keep = int'(eff_used) < BLOCK_QTY;
  assign keep_now = din_sop ? sop_keep : keep_r;
  assign word_idx = din_sop ? '0 : offs;

  assign wr_en   = din_valid && keep_now;             // write in the same cycle
  assign wr_addr = ADDR_W'(int'(wr_bloc) * WORDS + int'(word_idx));
  assign wr_data = {din_imag, din_real};

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      keep_r       <= 1'b0;
      offs         <= '0;
      commit_r     <= 1'b0;
      wr_bloc      <= '0;
      bloc_used    <= '0;
      overflow_cnt <= '0;
    end else begin
      if (din_valid && din_sop) begin
        keep_r <= sop_keep;                           // decision held to eop
      end
      if (din_valid) begin
        offs <= din_eop ? '0 : word_idx + 1'b1;
      end
      commit_r <= din_valid && din_eop && keep_now;
      if (din_valid && din_eop && keep_now) begin
        wr_bloc <= (wr_bloc == BLOC_LAST) ? '0 : wr_bloc + 1'b1; // ready for next sop
      end
      bloc_used <= USED_W'(int'(bloc_used) + int'(commit_r) - int'(bloc_release));
      if (din_valid && din_eop && !keep_now) begin
        overflow_cnt <= overflow_cnt + 1'b1;          // whole packet lost
      end
    end
  end

  // per-block metadata, taken at the sop of a kept packet
  always_ff @(posedge clk_rd) begin
    if (din_valid && din_sop && sop_keep) begin
      exp_mem[wr_bloc]    <= din_exp;
      symbol_mem[wr_bloc] <= din_symbol;
      slot_mem[wr_bloc]   <= din_slot;
      frame_mem[wr_bloc]  <= din_frame;
    end
  end

  assign rd_exp    = exp_mem[rd_bloc];
  assign rd_symbol = symbol_mem[rd_bloc];
  assign rd_slot   = slot_mem[rd_bloc];
  assign rd_frame  = frame_mem[rd_bloc];

  a_commit_room: assert property (@(posedge clk_rd) disable iff (!rst_n)
    commit_r |-> int'(bloc_used) < BLOCK_QTY);         // sop check saw the room

  a_pkt_len: assert property (@(posedge clk_rd) disable iff (!rst_n)
    din_valid && !din_sop |-> int'(offs) < WORDS);    // no word past block end

endmodule

`default_nettype wire

// ==== verilog/sc_block_ram.sv ====
// simple dual-port storage for BLOCK_QTY blocks, registered read data
// reading a word written in the same cycle returns the previous content
`timescale 1ns/1ps
`default_nettype none

module sc_block_ram #(
  parameter  int SC_NUM    = 48,
  parameter  int BLOCK_QTY = 4,
  localparam int DEPTH     = BLOCK_QTY * (SC_NUM / sc_map_pkg::LANES),
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk_rd,
  input  logic                  wr_en,
  input  logic [ADDR_W-1:0]     wr_addr,
  input  sc_map_pkg::ram_word_t wr_data,
  input  logic [ADDR_W-1:0]     rd_addr,
  output sc_map_pkg::ram_word_t rd_data              // valid one cycle after rd_addr
);

  sc_map_pkg::ram_word_t mem [0:DEPTH-1];            // block-major, word-minor

  always_ff @(posedge clk_rd) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];                         // old data on collision
  end

endmodule

`default_nettype wire

// ==== verilog/sc_read_ctrl.sv ====
// emits one FFT_SIZE frame per credit, upper half first, guards zeroed
// dc_enable must stay static while frames are in flight
`timescale 1ns/1ps
`default_nettype none

module sc_read_ctrl #(
  parameter  int FFT_SIZE   = 64,
  parameter  int SC_NUM     = 48,
  parameter  int BLOCK_QTY  = 4,
  parameter  int CREDIT_MAX = 4,
  localparam int WORDS      = SC_NUM / sc_map_pkg::LANES,
  localparam int ADDR_W     = $clog2(BLOCK_QTY * WORDS),
  localparam int BLOC_W     = (BLOCK_QTY > 1) ? $clog2(BLOCK_QTY) : 1,
  localparam int USED_W     = $clog2(BLOCK_QTY + 1),
  localparam int IDX_W      = $clog2(FFT_SIZE)
) (
  input  logic                  clk_rd,
  input  logic                  rst_n,
  input  logic                  dc_enable,
  input  logic                  dout_credit,          // one pulse, one frame
  input  logic [USED_W-1:0]     bloc_used,
  input  sc_map_pkg::ram_word_t rd_data,
  output logic [ADDR_W-1:0]     rd_addr,
  output logic [BLOC_W-1:0]     rd_bloc,              // block of the output frame
  output logic                  bloc_release,
  output logic                  dout_valid,
  output logic                  dout_sop,
  output logic                  dout_eop,
  output sc_map_pkg::sample_t   dout_real,
  output sc_map_pkg::sample_t   dout_imag,
  output logic [IDX_W-1:0]      dout_index
);

  localparam int H        = SC_NUM / 2;
  localparam int LO_START = FFT_SIZE - H;             // first bin of lower half
  localparam int CRED_W   = $clog2(CREDIT_MAX + 1);
  localparam int SC_W     = $clog2(SC_NUM);
  localparam int LANE_W   = $clog2(sc_map_pkg::LANES);
  localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(FFT_SIZE - 1);
  localparam logic [CRED_W-1:0] CRED_MAX  = CRED_W'(CREDIT_MAX);
  localparam logic [BLOC_W-1:0] BLOC_LAST = BLOC_W'(BLOCK_QTY - 1);

  sc_map_pkg::rd_state_t state;
  logic [IDX_W-1:0]  idx;                             // index being issued
  logic [BLOC_W-1:0] iss_bloc;                        // block being addressed
  logic [CRED_W-1:0] cred;
  logic              last;
  logic              busy;
  logic              start;
  logic              occ;                             // idx carries a subcarrier
  logic [SC_W-1:0]   sc;
  logic [LANE_W-1:0] lane;
  logic [LANE_W-1:0] lane_q;                          // lane lined up with rd_data
  logic              occ_q;

  assign last = (state == sc_map_pkg::RUN) && (idx == IDX_LAST);
  // current block still counted in bloc_used until its release lands
  assign busy  = last || (state == sc_map_pkg::DRAIN);
  assign start = (cred != '0) && (int'(bloc_used) >= (busy ? 2 : 1))
              && (busy || state == sc_map_pkg::IDLE);

  // swapped order, upper half from bin 0, lower half at the top
  always_comb begin
    occ = 1'b0;
    sc  = '0;
    if (dc_enable && int'(idx) < H) begin
      occ = 1'b1;
      sc  = SC_W'(H + int'(idx));
    end else if (!dc_enable && idx != '0 && int'(idx) <= H) begin
      occ = 1'b1;
      sc  = SC_W'(H + int'(idx) - 1);                 // bin 0 left empty
    end else if (int'(idx) >= LO_START) begin
      occ = 1'b1;
      sc  = SC_W'(int'(idx) - LO_START);
    end
  end

  assign lane    = LANE_W'(int'(sc) % sc_map_pkg::LANES);
  assign rd_addr = ADDR_W'(int'(iss_bloc) * WORDS + int'(sc) / sc_map_pkg::LANES);

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      cred <= '0;
    end else if (dout_credit && !start && cred != CRED_MAX) begin
      cred <= cred + 1'b1;                            // saturates at CREDIT_MAX
    end else if (start && !dout_credit) begin
      cred <= cred - 1'b1;
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      state    <= sc_map_pkg::IDLE;
      idx      <= '0;
      iss_bloc <= '0;
    end else begin
      case (state)
        sc_map_pkg::IDLE:  if (start) state <= sc_map_pkg::RUN;
        sc_map_pkg::RUN:   if (last) state <= start ? sc_map_pkg::RUN : sc_map_pkg::DRAIN;
        sc_map_pkg::DRAIN: state <= start ? sc_map_pkg::RUN : sc_map_pkg::IDLE;
        default:           state <= sc_map_pkg::IDLE;
      endcase
      idx <= (state == sc_map_pkg::RUN && !last) ? idx + 1'b1 : '0;
      if (last) begin
        iss_bloc <= (iss_bloc == BLOC_LAST) ? '0 : iss_bloc + 1'b1;
      end
    end
  end

  // output stage, one cycle behind the issued index
  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
      dout_sop   <= 1'b0;
      dout_eop   <= 1'b0;
      dout_index <= '0;
      rd_bloc    <= '0;
      occ_q      <= 1'b0;
    end else begin
      dout_valid <= (state == sc_map_pkg::RUN);
      dout_sop   <= (state == sc_map_pkg::RUN) && (idx == '0);
      dout_eop   <= last;
      dout_index <= idx;
      occ_q      <= (state == sc_map_pkg::RUN) && occ; // guard bins forced to zero
      if (state == sc_map_pkg::RUN) begin
        rd_bloc <= iss_bloc;                          // metadata held over frame
      end
    end
  end

  always_ff @(posedge clk_rd) begin
    lane_q <= lane;
  end

  assign dout_real = occ_q ? rd_data[int'(lane_q)*sc_map_pkg::SAMPLE_W +: sc_map_pkg::SAMPLE_W]
                           : '0;
  assign dout_imag = occ_q ? rd_data[(sc_map_pkg::LANES + int'(lane_q))*sc_map_pkg::SAMPLE_W
                                     +: sc_map_pkg::SAMPLE_W] : '0;
  assign bloc_release = dout_eop;                     // used count drops next cycle

  a_cred_max: assert property (@(posedge clk_rd) disable iff (!rst_n)
    cred <= CRED_MAX);

  a_frame_len: assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_sop |-> ##(FFT_SIZE-1) (dout_eop && dout_index == IDX_LAST));

endmodule

`default_nettype wire

// ==== verilog/sc_map_top.sv ====
// subcarrier mapper, one clock, credit flow control on the output
// SC_NUM even and a multiple of 2*LANES, FFT_SIZE a power of two above SC_NUM
`timescale 1ns/1ps
`default_nettype none

module sc_map_top #(
  parameter  int FFT_SIZE   = 64,
  parameter  int SC_NUM     = 48,
  parameter  int BLOCK_QTY  = 4,
  parameter  int CREDIT_MAX = 4,
  localparam int ADDR_W     = $clog2(BLOCK_QTY * (SC_NUM / sc_map_pkg::LANES)),
  localparam int BLOC_W     = (BLOCK_QTY > 1) ? $clog2(BLOCK_QTY) : 1,
  localparam int USED_W     = $clog2(BLOCK_QTY + 1),
  localparam int IDX_W      = $clog2(FFT_SIZE)
) (
  input  logic                   clk_rd,
  input  logic                   rst_n,
  input  logic                   din_valid,
  input  logic                   din_sop,
  input  logic                   din_eop,
  input  sc_map_pkg::lane_word_t din_real,
  input  sc_map_pkg::lane_word_t din_imag,
  input  sc_map_pkg::exp_t       din_exp,             // taken at sop
  input  sc_map_pkg::symbol_t    din_symbol,
  input  sc_map_pkg::slot_t      din_slot,
  input  sc_map_pkg::frame_t     din_frame,
  input  logic                   dc_enable,
  input  logic                   dout_credit,
  output logic                   dout_valid,
  output logic                   dout_sop,
  output logic                   dout_eop,
  output sc_map_pkg::sample_t    dout_real,
  output sc_map_pkg::sample_t    dout_imag,
  output logic [IDX_W-1:0]       dout_index,
  output sc_map_pkg::exp_t       dout_exp,            // constant over a frame
  output sc_map_pkg::symbol_t    dout_symbol,
  output sc_map_pkg::slot_t      dout_slot,
  output sc_map_pkg::frame_t     dout_frame,
  output logic [USED_W-1:0]      bloc_used,
  output sc_map_pkg::count_t     overflow_cnt
);

  logic                  wr_en;
  logic [ADDR_W-1:0]     wr_addr;
  sc_map_pkg::ram_word_t wr_data;
  logic [ADDR_W-1:0]     rd_addr;
  sc_map_pkg::ram_word_t rd_data;
  logic [BLOC_W-1:0]     rd_bloc;                     // selects output metadata
  logic                  bloc_release;

  sc_write_ctrl #(
    .SC_NUM    (SC_NUM),
    .BLOCK_QTY (BLOCK_QTY)
  ) u_write (
    .clk_rd       (clk_rd),
    .rst_n        (rst_n),
    .din_valid    (din_valid),
    .din_sop      (din_sop),
    .din_eop      (din_eop),
    .din_real     (din_real),
    .din_imag     (din_imag),
    .din_exp      (din_exp),
    .din_symbol   (din_symbol),
    .din_slot     (din_slot),
    .din_frame    (din_frame),
    .bloc_release (bloc_release),
    .rd_bloc      (rd_bloc),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .bloc_used    (bloc_used),
    .overflow_cnt (overflow_cnt),
    .rd_exp       (dout_exp),
    .rd_symbol    (dout_symbol),
    .rd_slot      (dout_slot),
    .rd_frame     (dout_frame)
  );

  sc_block_ram #(
    .SC_NUM    (SC_NUM),
    .BLOCK_QTY (BLOCK_QTY)
  ) u_ram (
    .clk_rd  (clk_rd),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  sc_read_ctrl #(
    .FFT_SIZE   (FFT_SIZE),
    .SC_NUM     (SC_NUM),
    .BLOCK_QTY  (BLOCK_QTY),
    .CREDIT_MAX (CREDIT_MAX)
  ) u_read (
    .clk_rd       (clk_rd),
    .rst_n        (rst_n),
    .dc_enable    (dc_enable),
    .dout_credit  (dout_credit),
    .bloc_used    (bloc_used),
    .rd_data      (rd_data),
    .rd_addr      (rd_addr),
    .rd_bloc      (rd_bloc),
    .bloc_release (bloc_release),
    .dout_valid   (dout_valid),
    .dout_sop     (dout_sop),
    .dout_eop     (dout_eop),
    .dout_real    (dout_real),
    .dout_imag    (dout_imag),
    .dout_index   (dout_index)
  );

endmodule

`default_nettype wire

// ==== tests/sc_map_checks.svh ====
// typed compare tasks and error counters included in the testbench module
// wrong values count in err_cnt and timeouts or protocol faults in fail_cnt
`ifndef SC_MAP_CHECKS_SVH
`define SC_MAP_CHECKS_SVH

int err_cnt  = 0;                                   // wrong values seen
int fail_cnt = 0;                                   // timeouts and missing frames

task automatic note_failure(string msg);
  fail_cnt++;
  $display("FAILURE at %0t ns: %s", $time, msg);
endtask

task automatic check_sample(string name,
                            sc_map_pkg::sample_t got, sc_map_pkg::sample_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic check_exp(string name, sc_map_pkg::exp_t got, sc_map_pkg::exp_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic check_symbol(string name,
                            sc_map_pkg::symbol_t got, sc_map_pkg::symbol_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic check_slot(string name, sc_map_pkg::slot_t got, sc_map_pkg::slot_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic check_frame(string name, sc_map_pkg::frame_t got, sc_map_pkg::frame_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
  end
endtask

task automatic check_count(string name, sc_map_pkg::count_t got, sc_map_pkg::count_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

// single-bit flags
task automatic check_flag(string name, logic got, logic exp);
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
  end
endtask

// small indices and counts (dout_index, bloc_used)
task automatic check_num(string name, int got, int exp);
  if (got != exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

`endif

// ==== tests/sc_map_tb.sv ====
// directed testbench for sc_map_top at its default parameters
// inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module sc_map_tb;

  localparam int FFT_SIZE = 64;
  localparam int SC_NUM   = 48;
  localparam int LANES    = sc_map_pkg::LANES;
  localparam int SW       = sc_map_pkg::SAMPLE_W;
  localparam int WORDS    = SC_NUM / LANES;          // words per packet
  localparam int H        = SC_NUM / 2;
  localparam int TIMEOUT  = 400;                     // cycles allowed per wait

  logic                   clk_rd = 1'b0;
  logic                   rst_n;
  logic                   din_valid;
  logic                   din_sop;
  logic                   din_eop;
  sc_map_pkg::lane_word_t din_real;
  sc_map_pkg::lane_word_t din_imag;
  sc_map_pkg::exp_t       din_exp;
  sc_map_pkg::symbol_t    din_symbol;
  sc_map_pkg::slot_t      din_slot;
  sc_map_pkg::frame_t     din_frame;
  logic                   dc_enable;
  logic                   dout_credit;
  logic                   dout_valid;
  logic                   dout_sop;
  logic                   dout_eop;
  sc_map_pkg::sample_t    dout_real;
  sc_map_pkg::sample_t    dout_imag;
  logic [5:0]             dout_index;
  sc_map_pkg::exp_t       dout_exp;
  sc_map_pkg::symbol_t    dout_symbol;
  sc_map_pkg::slot_t      dout_slot;
  sc_map_pkg::frame_t     dout_frame;
  logic [2:0]             bloc_used;
  sc_map_pkg::count_t     overflow_cnt;

  sc_map_pkg::sample_t ref_re[$];                    // kept packets, subcarrier order
  sc_map_pkg::sample_t ref_im[$];
  sc_map_pkg::exp_t    ref_exp[$];
  sc_map_pkg::symbol_t ref_sym[$];
  sc_map_pkg::slot_t   ref_slot[$];
  sc_map_pkg::frame_t  ref_frm[$];
  int unsigned         seed;

  `include "sc_map_checks.svh"

  sc_map_top DUT (.*);

  always #2 clk_rd = ~clk_rd;                        // 4 ns period

  // subcarrier carried by bin k, -1 for an empty bin
  function automatic int expected_sc(int k, logic dc);
    if (dc && k < H) return H + k;
    if (!dc && k >= 1 && k <= H) return H + k - 1;   // DC bin stays empty
    if (k >= FFT_SIZE - H) return k - (FFT_SIZE - H);
    return -1;
  endfunction

  task automatic send_packet(sc_map_pkg::exp_t e, sc_map_pkg::symbol_t s,
                             sc_map_pkg::slot_t sl, sc_map_pkg::frame_t f, logic keep);
    sc_map_pkg::lane_word_t re;
    sc_map_pkg::lane_word_t im;
    for (int w = 0; w < WORDS; w++) begin
      re = $urandom();
      im = $urandom();
      @(posedge clk_rd);
      din_valid  <= 1'b1;
      din_sop    <= (w == 0);
      din_eop    <= (w == WORDS - 1);
      din_real   <= re;
      din_imag   <= im;
      din_exp    <= e;                               // only taken at sop
      din_symbol <= s;
      din_slot   <= sl;
      din_frame  <= f;
      for (int l = 0; l < LANES; l++) begin
        if (keep) begin
          ref_re.push_back(re[l*SW +: SW]);          // lane 0 is lowest subcarrier
          ref_im.push_back(im[l*SW +: SW]);
        end
      end
    end
    @(posedge clk_rd);
    din_valid <= 1'b0;
    din_sop   <= 1'b0;
    din_eop   <= 1'b0;
    if (keep) begin
      ref_exp.push_back(e);
      ref_sym.push_back(s);
      ref_slot.push_back(sl);
      ref_frm.push_back(f);
    end
  endtask

  task automatic give_credit();
    @(posedge clk_rd);
    dout_credit <= 1'b1;
    @(posedge clk_rd);
    dout_credit <= 1'b0;                             // single-cycle pulse
  endtask

  task automatic wait_used(int n);
    int t;
    t = 0;
    @(negedge clk_rd);
    while (int'(bloc_used) != n && t < TIMEOUT) begin
      @(negedge clk_rd);
      t++;
    end
    check_num("bloc_used", int'(bloc_used), n);
  endtask

  task automatic expect_no_frame(int cycles);
    repeat (cycles) begin
      @(negedge clk_rd);
      if (dout_sop === 1'b1) begin
        note_failure("dout_sop appeared although no frame was allowed");
        return;
      end
    end
  endtask

  task automatic collect_frame(logic dc);
    sc_map_pkg::sample_t exp_re[SC_NUM];
    sc_map_pkg::sample_t exp_im[SC_NUM];
    sc_map_pkg::exp_t    e;
    sc_map_pkg::symbol_t s;
    sc_map_pkg::slot_t   sl;
    sc_map_pkg::frame_t  f;
    int                  n;
    int                  sc;
    n = 0;
    @(negedge clk_rd);
    while (dout_sop !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_rd);
      n++;
    end
    if (dout_sop !== 1'b1) begin
      note_failure("no dout_sop within the timeout");
      return;
    end
    if (ref_exp.size() == 0) begin
      note_failure("a frame came out with no stored packet left");
      return;
    end
    for (int j = 0; j < SC_NUM; j++) begin
      exp_re[j] = ref_re.pop_front();
      exp_im[j] = ref_im.pop_front();
    end
    e  = ref_exp.pop_front();
    s  = ref_sym.pop_front();
    sl = ref_slot.pop_front();
    f  = ref_frm.pop_front();
    for (int i = 0; i < FFT_SIZE; i++) begin
      sc = expected_sc(i, dc);
      check_flag("dout_valid", dout_valid, 1'b1);
      check_flag("dout_sop", dout_sop, i == 0);
      check_flag("dout_eop", dout_eop, i == FFT_SIZE - 1);
      check_num("dout_index", int'(dout_index), i);
      check_sample("dout_real", dout_real, (sc < 0) ? sc_map_pkg::sample_t'(0) : exp_re[sc]);
      check_sample("dout_imag", dout_imag, (sc < 0) ? sc_map_pkg::sample_t'(0) : exp_im[sc]);
      check_exp("dout_exp", dout_exp, e);            // metadata held all frame
      check_symbol("dout_symbol", dout_symbol, s);
      check_slot("dout_slot", dout_slot, sl);
      check_frame("dout_frame", dout_frame, f);
      if (i < FFT_SIZE - 1) @(negedge clk_rd);
    end
  endtask

  task automatic test_reset();
    repeat (20) begin
      @(negedge clk_rd);
      check_flag("dout_valid", dout_valid, 1'b0);
    end
    check_num("bloc_used", int'(bloc_used), 0);
    check_count("overflow_cnt", overflow_cnt, 0);
  endtask

  task automatic test_single_frame();
    send_packet(6'd5, 4'd1, 8'd3, 10'd17, 1'b1);
    wait_used(1);
    give_credit();
    collect_frame(1'b0);
    @(negedge clk_rd);
    check_flag("dout_valid", dout_valid, 1'b0);      // exactly FFT_SIZE valid cycles
    wait_used(0);
  endtask

  task automatic test_no_credit();
    send_packet(6'd9, 4'd2, 8'd4, 10'd18, 1'b1);
    wait_used(1);
    expect_no_frame(200);
    check_num("bloc_used", int'(bloc_used), 1);      // still held
    give_credit();
    collect_frame(1'b0);
    wait_used(0);
  endtask

  task automatic test_three_frames();
    send_packet(6'd3, 4'd1, 8'd10, 10'd100, 1'b1);
    send_packet(6'd7, 4'd2, 8'd11, 10'd101, 1'b1);
    send_packet(6'd12, 4'd3, 8'd12, 10'd102, 1'b1);
    wait_used(3);
    fork
      repeat (3) give_credit();
      repeat (3) collect_frame(1'b0);                // frames may run back to back
    join
    wait_used(0);
  endtask

  task automatic test_overflow();
    send_packet(6'd20, 4'd4, 8'd20, 10'd200, 1'b1);
    send_packet(6'd21, 4'd5, 8'd21, 10'd201, 1'b1);
    send_packet(6'd22, 4'd6, 8'd22, 10'd202, 1'b1);
    send_packet(6'd23, 4'd7, 8'd23, 10'd203, 1'b1);
    send_packet(6'd63, 4'd15, 8'd255, 10'd1023, 1'b0); // buffer full, dropped
    wait_used(4);
    check_count("overflow_cnt", overflow_cnt, 1);
    fork
      repeat (4) give_credit();
      repeat (4) collect_frame(1'b0);
    join
    expect_no_frame(200);
    wait_used(0);
    if (ref_exp.size() != 0) note_failure("stored packets left without a frame");
  endtask

  task automatic test_dc_enabled();
    @(posedge clk_rd);
    dc_enable <= 1'b1;                               // buffer idle here
    send_packet(6'd33, 4'd8, 8'd40, 10'd300, 1'b1);
    wait_used(1);
    give_credit();
    collect_frame(1'b1);
    wait_used(0);
  endtask

  initial begin
    seed = $urandom(16041);
    rst_n       <= 1'b0;
    din_valid   <= 1'b0;
    din_sop     <= 1'b0;
    din_eop     <= 1'b0;
    din_real    <= '0;
    din_imag    <= '0;
    din_exp     <= '0;
    din_symbol  <= '0;
    din_slot    <= '0;
    din_frame   <= '0;
    dc_enable   <= 1'b0;
    dout_credit <= 1'b0;
    repeat (3) @(posedge clk_rd);
    rst_n <= 1'b1;
    test_reset();
    test_single_frame();
    test_no_credit();
    test_three_frames();
    test_overflow();
    test_dc_enabled();
    $display("checks done: %0d wrong values, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+tests
verilog/sc_map_pkg.sv
verilog/sc_write_ctrl.sv
verilog/sc_block_ram.sv
verilog/sc_read_ctrl.sv
verilog/sc_map_top.sv
tests/sc_map_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module sc_map_tb -f all.f --Mdir obj_dir -o sc_map_sim
	./obj_dir/sc_map_sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
